//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := exu_core_tb
FILELIST := sim.f
BUILD    := obj_dir
LOG      := sim.log
PASS     := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- sim.f
source/exu_pkg.sv
source/id2exe_if.sv
source/reg_file.sv
source/instr_decode.sv
source/execute.sv
source/fwd_unit.sv
source/exu_core_top.sv
test/exu_core_assertions.sv
test/exu_core_tb.sv

//--- source/execute.sv
// Execute stage ALU and branch unit
`timescale 1ns/1ns

module execute (
    id2exe_if.execute                       id2exe,
    input  logic                            fwd_wrb_rs1_i,
    input  logic                            fwd_wrb_rs2_i,
    input  logic [exu_pkg::XLEN-1:0]        wrb_rd_data_i,
    output logic [exu_pkg::XLEN-1:0]        ex_result_o,
    output logic                            ex_valid_o,
    output logic [exu_pkg::RF_AWIDTH-1:0]   ex_rd_addr_o,
    output logic                            ex_rd_wr_o,
    output logic                            redirect_o,
    output logic [exu_pkg::XLEN-1:0]        pc_new_o
);
    import exu_pkg::*;

    logic [XLEN-1:0] operand_rs1;
    logic [XLEN-1:0] operand_rs2;
    logic [XLEN-1:0] alu_opr1;
    logic [XLEN-1:0] alu_opr2;
    logic [4:0]      shift_amt;
    logic [XLEN:0]   cmp_diff;
    logic            cmp_zero;
    logic            cmp_neg;
    logic            cmp_overflow;
    logic            cmp_carry;
    logic            signed_lt;
    logic            branch_taken;

    // Writeback result overrides the stale register read
    assign operand_rs1 = fwd_wrb_rs1_i ? wrb_rd_data_i : id2exe.rs1_data;
    assign operand_rs2 = fwd_wrb_rs2_i ? wrb_rd_data_i : id2exe.rs2_data;

    // PC for AUIPC, immediate for OP-IMM, LUI and AUIPC
    assign alu_opr1 = (id2exe.opr1_sel == ALU_OPR1_PC) ? id2exe.pc : operand_rs1;
    assign alu_opr2 = (id2exe.opr2_sel == ALU_OPR2_IMM) ? id2exe.imm : operand_rs2;
    assign shift_amt = alu_opr2[4:0];

    // 33-bit subtract serves SUB, SLT(U) and every branch condition
    assign cmp_diff     = {1'b0, alu_opr1} - {1'b0, alu_opr2};
    assign cmp_zero     = ~|cmp_diff[XLEN-1:0];
    assign cmp_neg      = cmp_diff[XLEN-1];
    assign cmp_carry    = cmp_diff[XLEN];
    // Signs of the operands differ and the result sign disagrees with opr1
    assign cmp_overflow = (alu_opr1[XLEN-1] ^ alu_opr2[XLEN-1]) & (cmp_neg ^ alu_opr1[XLEN-1]);
    assign signed_lt    = cmp_neg ^ cmp_overflow;

    always_comb begin
        case (id2exe.alu_ops)
            ALU_OPS_ADD:       ex_result_o = alu_opr1 + alu_opr2;
            ALU_OPS_SUB:       ex_result_o = cmp_diff[XLEN-1:0];
            ALU_OPS_SLL:       ex_result_o = alu_opr1 << shift_amt;
            ALU_OPS_SLT:       ex_result_o = XLEN'(signed_lt);
            ALU_OPS_SLTU:      ex_result_o = XLEN'(cmp_carry);
            ALU_OPS_XOR:       ex_result_o = alu_opr1 ^ alu_opr2;
            ALU_OPS_SRL:       ex_result_o = alu_opr1 >> shift_amt;
            ALU_OPS_SRA:       ex_result_o = $unsigned($signed(alu_opr1) >>> shift_amt);
            ALU_OPS_OR:        ex_result_o = alu_opr1 | alu_opr2;
            ALU_OPS_AND:       ex_result_o = alu_opr1 & alu_opr2;
            ALU_OPS_COPY_OPR2: ex_result_o = alu_opr2;
            // Link value for JAL
            ALU_OPS_NEXT_PC:   ex_result_o = id2exe.pc_next;
            default:           ex_result_o = '0;
        endcase
    end

    // Branch condition from the compare flags
    always_comb begin
        case (id2exe.branch_ops)
            BR_OPS_EQ:  branch_taken = cmp_zero;
            BR_OPS_NE:  branch_taken = ~cmp_zero;
            BR_OPS_LT:  branch_taken = signed_lt;
            BR_OPS_GE:  branch_taken = ~signed_lt;
            // Borrow out means opr1 below opr2 unsigned
            BR_OPS_LTU: branch_taken = cmp_carry;
            BR_OPS_GEU: branch_taken = ~cmp_carry;
            default:    branch_taken = 1'b0;
        endcase
    end

    // Separate target adder, the ALU is busy with the compare or link value
    assign pc_new_o   = id2exe.pc + id2exe.imm;
    assign redirect_o = id2exe.valid & (id2exe.jump_req | branch_taken);

    // Toward the EX/WB register
    assign ex_valid_o   = id2exe.valid;
    assign ex_rd_addr_o = id2exe.rd_addr;
    assign ex_rd_wr_o   = id2exe.valid & id2exe.rd_wr_req;

endmodule : execute

//--- source/exu_core_top.sv
// Integer execute slice top
`timescale 1ns/1ns

module exu_core_top (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            instr_valid_i,
    input  logic [31:0]                     instr_i,
    input  logic [exu_pkg::XLEN-1:0]        pc_i,
    output logic                            wb_valid_o,
    output logic [exu_pkg::RF_AWIDTH-1:0]   wb_rd_addr_o,
    output logic [exu_pkg::XLEN-1:0]        wb_rd_data_o,
    output logic                            wb_rd_wr_o,
    output logic                            redirect_o,
    output logic [exu_pkg::XLEN-1:0]        pc_new_o
);
    import exu_pkg::*;

    // Register file read ports
    logic [RF_AWIDTH-1:0] rf_rs1_addr;
    logic [RF_AWIDTH-1:0] rf_rs2_addr;
    logic [XLEN-1:0]      rf_rs1_data;
    logic [XLEN-1:0]      rf_rs2_data;
    // Execute result toward EX/WB
    logic [XLEN-1:0]      ex_result;
    logic                 ex_valid;
    logic [RF_AWIDTH-1:0] ex_rd_addr;
    logic                 ex_rd_wr;
    // Forward selects
    logic                 fwd_wrb_rs1;
    logic                 fwd_wrb_rs2;

    // ID/EX stage bundle
    id2exe_if id2exe ();

    instr_decode u_instr_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rf_rs1_addr_o (rf_rs1_addr),
        .rf_rs2_addr_o (rf_rs2_addr),
        .rf_rs1_data_i (rf_rs1_data),
        .rf_rs2_data_i (rf_rs2_data),
        .id2exe        (id2exe.decode)
    );

    // Written from the writeback stage
    reg_file u_reg_file (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_addr_i (rf_rs1_addr),
        .rs2_addr_i (rf_rs2_addr),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data),
        .wr_en_i    (wb_rd_wr_o),
        .wr_addr_i  (wb_rd_addr_o),
        .wr_data_i  (wb_rd_data_o)
    );

    execute u_execute (
        .id2exe        (id2exe.execute),
        .fwd_wrb_rs1_i (fwd_wrb_rs1),
        .fwd_wrb_rs2_i (fwd_wrb_rs2),
        .wrb_rd_data_i (wb_rd_data_o),
        .ex_result_o   (ex_result),
        .ex_valid_o    (ex_valid),
        .ex_rd_addr_o  (ex_rd_addr),
        .ex_rd_wr_o    (ex_rd_wr),
        .redirect_o    (redirect_o),
        .pc_new_o      (pc_new_o)
    );

    fwd_unit u_fwd_unit (
        .clk           (clk),
        .reset_i       (reset_i),
        .id2exe        (id2exe.fwd),
        .ex_valid_i    (ex_valid),
        .ex_rd_addr_i  (ex_rd_addr),
        .ex_rd_wr_i    (ex_rd_wr),
        .ex_result_i   (ex_result),
        .fwd_wrb_rs1_o (fwd_wrb_rs1),
        .fwd_wrb_rs2_o (fwd_wrb_rs2),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_addr_o  (wb_rd_addr_o),
        .wb_rd_data_o  (wb_rd_data_o),
        .wb_rd_wr_o    (wb_rd_wr_o)
    );

endmodule : exu_core_top

//--- source/exu_pkg.sv
// Execute slice shared definitions
package exu_pkg;

    // Word width and register address width fixed by RV32I
    localparam int XLEN      = 32;
    localparam int RF_AWIDTH = 5;

    // Major opcodes of the supported groups
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // ALU operation codes
    localparam logic [3:0] ALU_OPS_ADD       = 4'd0;
    localparam logic [3:0] ALU_OPS_SUB       = 4'd1;
    localparam logic [3:0] ALU_OPS_SLL       = 4'd2;
    localparam logic [3:0] ALU_OPS_SLT       = 4'd3;
    localparam logic [3:0] ALU_OPS_SLTU      = 4'd4;
    localparam logic [3:0] ALU_OPS_XOR       = 4'd5;
    localparam logic [3:0] ALU_OPS_SRL       = 4'd6;
    localparam logic [3:0] ALU_OPS_SRA       = 4'd7;
    localparam logic [3:0] ALU_OPS_OR        = 4'd8;
    localparam logic [3:0] ALU_OPS_AND       = 4'd9;
    // LUI passes the immediate straight through
    localparam logic [3:0] ALU_OPS_COPY_OPR2 = 4'd10;
    // JAL return address
    localparam logic [3:0] ALU_OPS_NEXT_PC   = 4'd11;

    // Branch conditions
    localparam logic [2:0] BR_OPS_NONE = 3'd0;
    localparam logic [2:0] BR_OPS_EQ   = 3'd1;
    localparam logic [2:0] BR_OPS_NE   = 3'd2;
    localparam logic [2:0] BR_OPS_LT   = 3'd3;
    localparam logic [2:0] BR_OPS_GE   = 3'd4;
    localparam logic [2:0] BR_OPS_LTU  = 3'd5;
    localparam logic [2:0] BR_OPS_GEU  = 3'd6;

    // ALU operand selects
    localparam logic ALU_OPR1_REG = 1'b0;
    localparam logic ALU_OPR1_PC  = 1'b1;
    localparam logic ALU_OPR2_REG = 1'b0;
    localparam logic ALU_OPR2_IMM = 1'b1;

    // R and I formats, rs2 doubles as the low immediate bits
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } type_instr_ri_s;

    // B and J formats, immediate split around the register fields
    typedef struct packed {
        logic       imm_hi;
        logic [5:0] imm_mid;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_lo;
        logic       imm_b11;
        logic [6:0] opcode;
    } type_instr_bj_s;

    typedef union packed {
        type_instr_ri_s ri;
        type_instr_bj_s bj;
    } type_instr_u;

endpackage : exu_pkg

//--- source/fwd_unit.sv
// Writeback forwarding and EX/WB stage
`timescale 1ns/1ns

module fwd_unit (
    input  logic                            clk,
    input  logic                            reset_i,
    id2exe_if.fwd                           id2exe,
    input  logic                            ex_valid_i,
    input  logic [exu_pkg::RF_AWIDTH-1:0]   ex_rd_addr_i,
    input  logic                            ex_rd_wr_i,
    input  logic [exu_pkg::XLEN-1:0]        ex_result_i,
    output logic                            fwd_wrb_rs1_o,
    output logic                            fwd_wrb_rs2_o,
    output logic                            wb_valid_o,
    output logic [exu_pkg::RF_AWIDTH-1:0]   wb_rd_addr_o,
    output logic [exu_pkg::XLEN-1:0]        wb_rd_data_o,
    output logic                            wb_rd_wr_o
);
    logic wb_writes;

    // Only a live write to a real register can be forwarded
    assign wb_writes = wb_valid_o & wb_rd_wr_o & (wb_rd_addr_o != '0);

    assign fwd_wrb_rs1_o = id2exe.valid & wb_writes & (id2exe.rs1_addr == wb_rd_addr_o);
    assign fwd_wrb_rs2_o = id2exe.valid & wb_writes & (id2exe.rs2_addr == wb_rd_addr_o);

    // EX/WB control
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_o <= 1'b0;
            wb_rd_wr_o <= 1'b0;
        end else begin
            wb_valid_o <= ex_valid_i;
            wb_rd_wr_o <= ex_valid_i & ex_rd_wr_i;
        end
    end

    // EX/WB payload
    always_ff @(posedge clk) begin
        wb_rd_addr_o <= ex_rd_addr_i;
        wb_rd_data_o <= ex_result_i;
    end

endmodule : fwd_unit

//--- source/id2exe_if.sv
// Decode to execute stage bundle
`timescale 1ns/1ns

interface id2exe_if;
    import exu_pkg::*;

    // Instruction qualifier and program counters
    logic                 valid;
    logic [XLEN-1:0]      pc;
    logic [XLEN-1:0]      pc_next;
    // Operand data
    logic [XLEN-1:0]      imm;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    // Register addresses, used by forwarding
    logic [RF_AWIDTH-1:0] rs1_addr;
    logic [RF_AWIDTH-1:0] rs2_addr;
    logic [RF_AWIDTH-1:0] rd_addr;
    // Execute controls
    logic [3:0]           alu_ops;
    logic [2:0]           branch_ops;
    logic                 jump_req;
    logic                 opr1_sel;
    logic                 opr2_sel;
    logic                 rd_wr_req;

    modport decode (
        output valid, pc, pc_next, imm, rs1_data, rs2_data, rs1_addr, rs2_addr, rd_addr,
        output alu_ops, branch_ops, jump_req, opr1_sel, opr2_sel, rd_wr_req
    );

    modport execute (
        input valid, pc, pc_next, imm, rs1_data, rs2_data, rs1_addr, rs2_addr, rd_addr,
        input alu_ops, branch_ops, jump_req, opr1_sel, opr2_sel, rd_wr_req
    );

    modport fwd (
        input valid, rs1_addr, rs2_addr
    );

endinterface : id2exe_if

//--- source/instr_decode.sv
// Instruction decoder and ID/EX stage
`timescale 1ns/1ns

module instr_decode (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            instr_valid_i,
    input  exu_pkg::type_instr_u            instr_i,
    input  logic [exu_pkg::XLEN-1:0]        pc_i,
    output logic [exu_pkg::RF_AWIDTH-1:0]   rf_rs1_addr_o,
    output logic [exu_pkg::RF_AWIDTH-1:0]   rf_rs2_addr_o,
    input  logic [exu_pkg::XLEN-1:0]        rf_rs1_data_i,
    input  logic [exu_pkg::XLEN-1:0]        rf_rs2_data_i,
    id2exe_if.decode                        id2exe
);
    import exu_pkg::*;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm;
    logic [3:0]      alu_ops;
    logic [2:0]      branch_ops;
    logic            jump_req;
    logic            opr1_sel;
    logic            opr2_sel;
    logic            rd_wr_req;

    // funct3 to ALU code, alt picks SUB or SRA
    function automatic logic [3:0] alu_from_funct3(input logic [2:0] funct3, input logic alt);
        logic [3:0] ops;
        case (funct3)
            3'b000:  ops = alt ? ALU_OPS_SUB : ALU_OPS_ADD;
            3'b001:  ops = ALU_OPS_SLL;
            3'b010:  ops = ALU_OPS_SLT;
            3'b011:  ops = ALU_OPS_SLTU;
            3'b100:  ops = ALU_OPS_XOR;
            3'b101:  ops = alt ? ALU_OPS_SRA : ALU_OPS_SRL;
            3'b110:  ops = ALU_OPS_OR;
            default: ops = ALU_OPS_AND;
        endcase
        return ops;
    endfunction

    // Register file read addresses straight from the R/I view
    assign rf_rs1_addr_o = instr_i.ri.rs1;
    assign rf_rs2_addr_o = instr_i.ri.rs2;

    // I and U immediates from the R/I view
    assign imm_i = {{20{instr_i.ri.funct7[6]}}, instr_i.ri.funct7, instr_i.ri.rs2};
    assign imm_u = {instr_i.ri.funct7, instr_i.ri.rs2, instr_i.ri.rs1, instr_i.ri.funct3, 12'b0};
    // B and J immediates from the B/J view
    assign imm_b = {{20{instr_i.bj.imm_hi}}, instr_i.bj.imm_b11, instr_i.bj.imm_mid,
                    instr_i.bj.imm_lo, 1'b0};
    assign imm_j = {{12{instr_i.bj.imm_hi}}, instr_i.bj.rs1, instr_i.bj.funct3,
                    instr_i.bj.rs2[0], instr_i.bj.imm_mid, instr_i.bj.rs2[4:1], 1'b0};

    always_comb begin
        // Unknown opcodes fall through with no register write
        alu_ops    = ALU_OPS_ADD;
        branch_ops = BR_OPS_NONE;
        jump_req   = 1'b0;
        opr1_sel   = ALU_OPR1_REG;
        opr2_sel   = ALU_OPR2_REG;
        rd_wr_req  = 1'b0;
        imm        = imm_i;
        case (instr_i.ri.opcode)
            OPC_OP: begin
                alu_ops   = alu_from_funct3(instr_i.ri.funct3, instr_i.ri.funct7[5]);
                rd_wr_req = 1'b1;
            end
            OPC_OP_IMM: begin
                // funct7 only matters for SRAI here, ADDI never subtracts
                alu_ops   = alu_from_funct3(instr_i.ri.funct3,
                                            (instr_i.ri.funct3 == 3'b101) & instr_i.ri.funct7[5]);
                opr2_sel  = ALU_OPR2_IMM;
                rd_wr_req = 1'b1;
            end
            OPC_LUI: begin
                alu_ops   = ALU_OPS_COPY_OPR2;
                opr2_sel  = ALU_OPR2_IMM;
                imm       = imm_u;
                rd_wr_req = 1'b1;
            end
            OPC_AUIPC: begin
                opr1_sel  = ALU_OPR1_PC;
                opr2_sel  = ALU_OPR2_IMM;
                imm       = imm_u;
                rd_wr_req = 1'b1;
            end
            OPC_BRANCH: begin
                imm = imm_b;
                case (instr_i.bj.funct3)
                    3'b000:  branch_ops = BR_OPS_EQ;
                    3'b001:  branch_ops = BR_OPS_NE;
                    3'b100:  branch_ops = BR_OPS_LT;
                    3'b101:  branch_ops = BR_OPS_GE;
                    3'b110:  branch_ops = BR_OPS_LTU;
                    3'b111:  branch_ops = BR_OPS_GEU;
                    default: branch_ops = BR_OPS_NONE;
                endcase
            end
            OPC_JAL: begin
                alu_ops   = ALU_OPS_NEXT_PC;
                jump_req  = 1'b1;
                imm       = imm_j;
                rd_wr_req = 1'b1;
            end
            default: begin
                rd_wr_req = 1'b0;
            end
        endcase
    end

    // ID/EX control
    always_ff @(posedge clk) begin
        if (reset_i) begin
            id2exe.valid      <= 1'b0;
            id2exe.alu_ops    <= ALU_OPS_ADD;
            id2exe.branch_ops <= BR_OPS_NONE;
            id2exe.jump_req   <= 1'b0;
            id2exe.opr1_sel   <= ALU_OPR1_REG;
            id2exe.opr2_sel   <= ALU_OPR2_REG;
            id2exe.rd_wr_req  <= 1'b0;
        end else begin
            id2exe.valid      <= instr_valid_i;
            id2exe.alu_ops    <= alu_ops;
            id2exe.branch_ops <= branch_ops;
            id2exe.jump_req   <= jump_req;
            id2exe.opr1_sel   <= opr1_sel;
            id2exe.opr2_sel   <= opr2_sel;
            id2exe.rd_wr_req  <= rd_wr_req;
        end
    end

    // ID/EX payload, loaded with each new instruction
    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            id2exe.pc       <= pc_i;
            id2exe.pc_next  <= pc_i + XLEN'(4);
            id2exe.imm      <= imm;
            id2exe.rs1_data <= rf_rs1_data_i;
            id2exe.rs2_data <= rf_rs2_data_i;
            id2exe.rs1_addr <= instr_i.ri.rs1;
            id2exe.rs2_addr <= instr_i.ri.rs2;
            id2exe.rd_addr  <= instr_i.ri.rd;
        end
    end

endmodule : instr_decode

//--- source/reg_file.sv
// Integer register file
`timescale 1ns/1ns

module reg_file (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic [exu_pkg::RF_AWIDTH-1:0]   rs1_addr_i,
    input  logic [exu_pkg::RF_AWIDTH-1:0]   rs2_addr_i,
    output logic [exu_pkg::XLEN-1:0]        rs1_data_o,
    output logic [exu_pkg::XLEN-1:0]        rs2_data_o,
    input  logic                            wr_en_i,
    input  logic [exu_pkg::RF_AWIDTH-1:0]   wr_addr_i,
    input  logic [exu_pkg::XLEN-1:0]        wr_data_i
);
    import exu_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];
    logic            wr_active;

    // Read with x0 tied low and write-first bypass
    function automatic logic [XLEN-1:0] rd_port(input logic [RF_AWIDTH-1:0] addr);
        logic [XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_active && (wr_addr_i == addr)) begin
            data = wr_data_i;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    assign wr_active = wr_en_i & (wr_addr_i != '0);

    // Reevaluated on any change of the storage or the write port
    always_comb begin
        rs1_data_o = rd_port(rs1_addr_i);
        rs2_data_o = rd_port(rs2_addr_i);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_active) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

endmodule : reg_file

//--- test/exu_core_assertions.sv
// Pipeline control assertions
`timescale 1ns/1ns

module exu_core_assertions (
    input logic clk,
    input logic reset_i,
    input logic instr_valid_i,
    input logic wb_valid_i,
    input logic redirect_i
);

    // Writeback stays quiet while reset holds
    wb_idle_in_reset: assert property (@(posedge clk) reset_i |=> !wb_valid_i)
        else $error("wb_valid_o high during reset");

    // Fixed two-cycle latency from issue to writeback
    issue_to_wb: assert property (@(posedge clk) disable iff (reset_i)
        instr_valid_i |-> ##2 wb_valid_i)
        else $error("instr_valid_i not followed by wb_valid_o two cycles later");

    // A redirecting instruction retires on the next cycle
    redirect_to_wb: assert property (@(posedge clk) disable iff (reset_i)
        redirect_i |=> wb_valid_i)
        else $error("redirect_o not followed by wb_valid_o");

endmodule : exu_core_assertions

bind exu_core_top exu_core_assertions i_assertions (
    .clk           (clk),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .wb_valid_i    (wb_valid_o),
    .redirect_i    (redirect_o)
);

//--- test/exu_core_tb.sv
// Execute slice testbench
`timescale 1ns/1ns

module exu_core_tb;
    import exu_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_INSTR    = 400;

    // Instruction classes, used to name failing checks
    localparam logic [2:0] KIND_IDLE   = 3'd0;
    localparam logic [2:0] KIND_OP     = 3'd1;
    localparam logic [2:0] KIND_OP_IMM = 3'd2;
    localparam logic [2:0] KIND_LUI    = 3'd3;
    localparam logic [2:0] KIND_AUIPC  = 3'd4;
    localparam logic [2:0] KIND_BRANCH = 3'd5;
    localparam logic [2:0] KIND_JAL    = 3'd6;
    localparam logic [2:0] KIND_UNSUP  = 3'd7;

    // One expected retirement, a bubble has valid low
    typedef struct packed {
        logic [2:0]  kind;
        logic        valid;
        logic        wr;
        logic [4:0]  addr;
        logic [31:0] data;
        logic        redir;
        logic [31:0] pc_new;
    } exp_t;

    logic            clk;
    logic            reset_i;
    logic            instr_valid_i;
    logic [31:0]     instr_i;
    logic [XLEN-1:0] pc_i;
    logic            wb_valid_o;
    logic [4:0]      wb_rd_addr_o;
    logic [XLEN-1:0] wb_rd_data_o;
    logic            wb_rd_wr_o;
    logic            redirect_o;
    logic [XLEN-1:0] pc_new_o;

    integer      seed;
    int          errors;
    int          checks;
    int          issued;
    logic [31:0] r;
    // Architectural state of the reference model
    logic [31:0] regs [0:31];
    logic [31:0] pc;
    // Oldest entry is in writeback, the one behind it in execute
    exp_t        exp_q [$];

    exu_core_top i_dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_addr_o  (wb_rd_addr_o),
        .wb_rd_data_o  (wb_rd_data_o),
        .wb_rd_wr_o    (wb_rd_wr_o),
        .redirect_o    (redirect_o),
        .pc_new_o      (pc_new_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Bounded by at most two cycles per instruction plus reset
    initial begin
        #((NUM_INSTR * 3 + RESET_CYCLES + 50) * CLK_PERIOD);
        $display("Watchdog expired before the instruction stream completed");
        $display("Test failures found");
        $finish;
    end

    function automatic string kind_name(input logic [2:0] kind);
        case (kind)
            KIND_OP:     return "op";
            KIND_OP_IMM: return "op_imm";
            KIND_LUI:    return "lui";
            KIND_AUIPC:  return "auipc";
            KIND_BRANCH: return "branch";
            KIND_JAL:    return "jal";
            KIND_UNSUP:  return "unsupported";
            default:     return "idle";
        endcase
    endfunction

    // RV32I integer semantics, alt selects SUB and SRA
    function automatic logic [31:0] alu_result(input logic [2:0] funct3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        case (funct3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Branch condition by funct3
    function automatic logic branch_outcome(input logic [2:0] funct3,
                                            input logic [31:0] a, input logic [31:0] b);
        case (funct3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("Error %s: expected %h, actual %h", name, expected, actual);
    endtask

    // Build one random instruction, drive it and step the model
    task automatic issue_instr();
        logic [31:0] rnd;
        logic [31:0] rimm;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        alt;
        logic [6:0]  funct7;
        logic [11:0] imm12;
        logic [31:0] imm;
        logic [31:0] word;
        exp_t        e;
        rnd    = $random(seed);
        rimm   = $random(seed);
        funct3 = rnd[6:4];
        // Only x0 to x7, so dependencies are frequent
        rd     = {2'b00, rnd[9:7]};
        rs1    = {2'b00, rnd[12:10]};
        rs2    = {2'b00, rnd[15:13]};
        alt    = rnd[16];
        e       = '0;
        e.valid = 1'b1;
        e.addr  = rd;
        case (rnd[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: begin
                funct7 = (alt && (funct3 == 3'b000 || funct3 == 3'b101)) ? 7'h20 : 7'h00;
                word   = {funct7, rs2, rs1, funct3, rd, OPC_OP};
                e.kind = KIND_OP;
                e.wr   = 1'b1;
                e.data = alu_result(funct3, funct7[5], regs[rs1], regs[rs2]);
            end
            4'd4, 4'd5, 4'd6, 4'd15: begin
                imm12 = rimm[11:0];
                // Shift immediates carry only the amount and the SRAI flag
                if (funct3 == 3'b001) begin
                    imm12[11:5] = 7'h00;
                end
                if (funct3 == 3'b101) begin
                    imm12[11:5] = alt ? 7'h20 : 7'h00;
                end
                imm    = {{20{imm12[11]}}, imm12};
                word   = {imm12, rs1, funct3, rd, OPC_OP_IMM};
                e.kind = KIND_OP_IMM;
                e.wr   = 1'b1;
                e.data = alu_result(funct3, alt && (funct3 == 3'b101), regs[rs1], imm);
            end
            4'd7, 4'd8: begin
                imm    = {rimm[31:12], 12'h000};
                word   = {rimm[31:12], rd, (rnd[3:0] == 4'd7) ? OPC_LUI : OPC_AUIPC};
                e.kind = (rnd[3:0] == 4'd7) ? KIND_LUI : KIND_AUIPC;
                e.wr   = 1'b1;
                e.data = (rnd[3:0] == 4'd7) ? imm : pc + imm;
            end
            4'd9, 4'd10, 4'd11: begin
                // Map the two reserved funct3 codes onto BLT and BGE
                if (funct3 == 3'b010 || funct3 == 3'b011) begin
                    funct3 = funct3 ^ 3'b110;
                end
                imm      = {{19{rimm[12]}}, rimm[12:1], 1'b0};
                word     = {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], OPC_BRANCH};
                e.kind   = KIND_BRANCH;
                e.redir  = branch_outcome(funct3, regs[rs1], regs[rs2]);
                e.pc_new = pc + imm;
            end
            4'd12, 4'd13: begin
                imm      = {{11{rimm[20]}}, rimm[20:1], 1'b0};
                word     = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
                e.kind   = KIND_JAL;
                e.wr     = 1'b1;
                e.data   = pc + 32'd4;
                e.redir  = 1'b1;
                e.pc_new = pc + imm;
            end
            default: begin
                // Load and store opcodes are outside this slice
                word   = {rimm[31:12], rd, alt ? 7'b0100011 : 7'b0000011};
                e.kind = KIND_UNSUP;
            end
        endcase
        instr_valid_i = 1'b1;
        instr_i       = word;
        pc_i          = pc;
        exp_q.push_back(e);
        if (e.wr && (rd != 5'd0)) begin
            regs[rd] = e.data;
        end
        // Stimulus follows taken branches and jumps
        pc = e.redir ? e.pc_new : pc + 32'd4;
    endtask

    // One clock cycle, either an instruction or a bubble
    task automatic run_cycle(input logic do_issue);
        exp_t  e;
        string name;
        exp_t  bubble;
        bubble = '0;
        if (do_issue) begin
            issue_instr();
        end else begin
            instr_valid_i = 1'b0;
            exp_q.push_back(bubble);
        end
        // Outputs are settled mid-cycle
        @(negedge clk);
        e    = exp_q[exp_q.size() - 2];
        name = kind_name(e.kind);
        checks++;
        if (redirect_o !== e.redir) begin
            report_mismatch({name, " redirect_o"}, {31'b0, e.redir}, {31'b0, redirect_o});
        end
        if (e.redir && (pc_new_o !== e.pc_new)) begin
            report_mismatch({name, " pc_new_o"}, e.pc_new, pc_new_o);
        end
        e    = exp_q.pop_front();
        name = kind_name(e.kind);
        checks++;
        if (wb_valid_o !== e.valid) begin
            report_mismatch({name, " wb_valid_o"}, {31'b0, e.valid}, {31'b0, wb_valid_o});
        end
        if (e.valid && (wb_rd_wr_o !== e.wr)) begin
            report_mismatch({name, " wb_rd_wr_o"}, {31'b0, e.wr}, {31'b0, wb_rd_wr_o});
        end
        if (e.valid && e.wr && (wb_rd_addr_o !== e.addr)) begin
            report_mismatch({name, " wb_rd_addr_o"}, {27'b0, e.addr}, {27'b0, wb_rd_addr_o});
        end
        if (e.valid && e.wr && (wb_rd_data_o !== e.data)) begin
            report_mismatch({name, " wb_rd_data_o"}, e.data, wb_rd_data_o);
        end
        @(posedge clk);
        #2;
    endtask

    initial begin
        exp_t bubble;
        seed          = 32'h145b_d08d;
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = 32'h0;
        pc_i          = 32'h0;
        errors        = 0;
        checks        = 0;
        issued        = 0;
        pc            = 32'h0000_1000;
        bubble        = '0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'h0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset_i = 1'b0;
        // Pipeline is empty right after reset
        exp_q.push_back(bubble);
        exp_q.push_back(bubble);
        repeat (3) run_cycle(1'b0);
        while (issued < NUM_INSTR) begin
            r = $random(seed);
            if (r[1:0] == 2'b00) begin
                run_cycle(1'b0);
            end
            run_cycle(1'b1);
            issued++;
        end
        // Drain the last two stages
        repeat (2) run_cycle(1'b0);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : exu_core_tb
